//--- rtl/flitPkg.sv
package flitPkg;

  // link geometry.
  localparam int NUM_PORTS  = 5;
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // payload and kind of one flit.
  typedef logic [31:0] flitData_t;
  typedef logic [2:0]  flitId_t;

  // slice budget, counted in flits, carried in the low payload bits of a header.
  typedef logic [11:0] sliceLen_t;

  // source port number sent along with each flit.
  typedef logic [2:0] portIdx_t;

  // buffer pointers and fill level, the level needs one extra bit.
  typedef logic [FIFO_PTR_W-1:0] fifoPtr_t;
  typedef logic [FIFO_PTR_W:0]   fifoCount_t;

  localparam flitId_t HEADER_ID = 3'd1;  // marks a header flit.

endpackage

//--- rtl/arbPkg.sv
package arbPkg;

  // one-hot grant states.
  typedef enum logic [5:0] {
    IDLE    = 6'b000001,
    GRANT_L = 6'b000010,
    GRANT_N = 6'b000100,
    GRANT_E = 6'b001000,
    GRANT_W = 6'b010000,
    GRANT_S = 6'b100000
  } arbState_t;

  // port indices, also the cyclic priority order.
  localparam int PORT_L = 0;
  localparam int PORT_N = 1;
  localparam int PORT_E = 2;
  localparam int PORT_W = 3;
  localparam int PORT_S = 4;

  localparam int RESET_BUDGET = 1;  // budget held until the first header arrives.

endpackage

//--- rtl/portBuffer.sv
`timescale 1ns/1ps

module portBuffer
  import flitPkg::*;
  import arbPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      inValid,
  output logic      inReady,
  input  flitId_t   inFlitId,
  input  flitData_t inFlit,
  input  logic      pop,
  output logic      notEmpty,
  output flitId_t   headFlitId,
  output flitData_t headFlit,
  output sliceLen_t budget
);

  flitData_t  mem [FIFO_DEPTH];
  flitId_t    idMem [FIFO_DEPTH];
  fifoPtr_t   wrPtr;
  fifoPtr_t   rdPtr;
  fifoCount_t count;
  logic       wrEn;
  logic       rdEn;

  // wrap explicitly so a depth that is not a power of two still works.
  function automatic fifoPtr_t nextPtr(input fifoPtr_t ptr);
    return (ptr == fifoPtr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign inReady    = (count != fifoCount_t'(FIFO_DEPTH));
  assign notEmpty   = (count != '0);
  assign wrEn       = inValid && inReady;
  assign rdEn       = pop && notEmpty;
  assign headFlit   = mem[rdPtr];
  assign headFlitId = idMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (wrEn)
    begin
      mem[wrPtr]   <= inFlit;
      idMem[wrPtr] <= inFlitId;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (wrEn)
        wrPtr <= nextPtr(wrPtr);
      if (rdEn)
        rdPtr <= nextPtr(rdPtr);
      case ({wrEn, rdEn})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or write and pop together.
      endcase
    end
  end

  // every header written reloads the budget of this port.
  always_ff @(posedge clk)
  begin
    if (rst)
      budget <= sliceLen_t'(RESET_BUDGET);
    else if (wrEn && (inFlitId == HEADER_ID))
      budget <= inFlit[$bits(sliceLen_t)-1:0];
  end

endmodule

//--- rtl/sliceArbiter.sv
`timescale 1ns/1ps

module sliceArbiter
  import flitPkg::*;
  import arbPkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic      [NUM_PORTS-1:0]  req,
  input  sliceLen_t [NUM_PORTS-1:0]  budget,
  input  logic                       slotFree,
  output logic      [NUM_PORTS-1:0]  pop,
  output logic                       load,
  output portIdx_t                   srcPort
);

  arbState_t                   state;
  arbState_t                   nextState;
  sliceLen_t                   sentCount;
  logic [$bits(sliceLen_t):0]  sentNext;
  sliceLen_t                   curBudget;
  portIdx_t                    curPort;
  logic                        granted;

  function automatic arbState_t grantOf(input int idx);
    arbState_t s;
    case (idx)
      PORT_L:  s = GRANT_L;
      PORT_N:  s = GRANT_N;
      PORT_E:  s = GRANT_E;
      PORT_W:  s = GRANT_W;
      PORT_S:  s = GRANT_S;
      default: s = IDLE;
    endcase
    return s;
  endfunction

  // first requester among span ports from first on, wrapping around.
  // scanned backwards so the earliest port in cyclic order wins.
  function automatic arbState_t pickNext(input logic [NUM_PORTS-1:0] r,
                                         input int first, input int span);
    arbState_t s;
    int        idx;
    s = IDLE;
    for (int k = span - 1; k >= 0; k--)
    begin
      idx = (first + k) % NUM_PORTS;
      if (r[idx])
        s = grantOf(idx);
    end
    return s;
  endfunction

  always_comb
  begin
    granted = 1'b1;
    curPort = portIdx_t'(PORT_L);
    case (state)
      GRANT_L: curPort = portIdx_t'(PORT_L);
      GRANT_N: curPort = portIdx_t'(PORT_N);
      GRANT_E: curPort = portIdx_t'(PORT_E);
      GRANT_W: curPort = portIdx_t'(PORT_W);
      GRANT_S: curPort = portIdx_t'(PORT_S);
      default: granted = 1'b0;
    endcase
  end

  assign load    = granted && req[curPort] && slotFree;
  assign pop     = load ? ({{(NUM_PORTS-1){1'b0}}, 1'b1} << curPort) : '0;
  assign srcPort = curPort;

  // a zero budget still lets one flit through.
  assign curBudget = (budget[curPort] == '0) ? sliceLen_t'(1) : budget[curPort];

  // flits sent in this slice once the pop of this cycle is counted.
  assign sentNext = {1'b0, sentCount} + {{$bits(sliceLen_t){1'b0}}, load};

  always_comb
  begin
    if (!granted)
      nextState = pickNext(req, PORT_L, NUM_PORTS);
    else if (req[curPort] && (sentNext < {1'b0, curBudget}))
      nextState = state;
    else
      nextState = pickNext(req, int'(curPort) + 1, NUM_PORTS - 1);  // skip current.
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= IDLE;
      sentCount <= '0;
    end
    else
    begin
      state <= nextState;
      if (nextState != state)
        sentCount <= '0;  // new slice.
      else
        sentCount <= sentNext[$bits(sliceLen_t)-1:0];
    end
  end

endmodule

//--- rtl/linkOutput.sv
`timescale 1ns/1ps

module linkOutput
  import flitPkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  flitData_t [NUM_PORTS-1:0] headFlit,
  input  flitId_t   [NUM_PORTS-1:0] headFlitId,
  input  logic                      load,
  input  portIdx_t                  srcPort,
  output logic                      slotFree,
  output logic                      outValid,
  input  logic                      outReady,
  output flitData_t                 outFlit,
  output flitId_t                   outFlitId,
  output portIdx_t                  outPort
);

  // register empty, or its flit leaves on this edge.
  assign slotFree = !outValid || outReady;

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (load)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;
  end

  // load only comes with slotFree, so a stalled flit is never overwritten.
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      outFlit   <= headFlit[srcPort];
      outFlitId <= headFlitId[srcPort];
      outPort   <= srcPort;
    end
  end

endmodule

//--- rtl/routerOutputStage.sv
`timescale 1ns/1ps

module routerOutputStage
  import flitPkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic      [NUM_PORTS-1:0] inValid,
  output logic      [NUM_PORTS-1:0] inReady,
  input  flitId_t   [NUM_PORTS-1:0] inFlitId,
  input  flitData_t [NUM_PORTS-1:0] inFlit,
  output logic                      outValid,
  input  logic                      outReady,
  output flitData_t                 outFlit,
  output flitId_t                   outFlitId,
  output portIdx_t                  outPort
);

  logic      [NUM_PORTS-1:0] notEmpty;
  logic      [NUM_PORTS-1:0] pop;
  sliceLen_t [NUM_PORTS-1:0] budget;
  flitData_t [NUM_PORTS-1:0] headFlit;
  flitId_t   [NUM_PORTS-1:0] headFlitId;
  logic                      load;
  logic                      slotFree;
  portIdx_t                  srcPort;

  // one buffer per input port, in L, N, E, W, S order.
  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gPort
    portBuffer u_portBuffer (
      .clk        (clk),
      .rst        (rst),
      .inValid    (inValid[p]),
      .inReady    (inReady[p]),
      .inFlitId   (inFlitId[p]),
      .inFlit     (inFlit[p]),
      .pop        (pop[p]),
      .notEmpty   (notEmpty[p]),
      .headFlitId (headFlitId[p]),
      .headFlit   (headFlit[p]),
      .budget     (budget[p])
    );
  end

  sliceArbiter u_sliceArbiter (
    .clk      (clk),
    .rst      (rst),
    .req      (notEmpty),
    .budget   (budget),
    .slotFree (slotFree),
    .pop      (pop),
    .load     (load),
    .srcPort  (srcPort)
  );

  linkOutput u_linkOutput (
    .clk        (clk),
    .rst        (rst),
    .headFlit   (headFlit),
    .headFlitId (headFlitId),
    .load       (load),
    .srcPort    (srcPort),
    .slotFree   (slotFree),
    .outValid   (outValid),
    .outReady   (outReady),
    .outFlit    (outFlit),
    .outFlitId  (outFlitId),
    .outPort    (outPort)
  );

endmodule

//--- verification/routerOutputStage_chk.sv
`timescale 1ns/1ps

module routerOutputStage_chk
  import flitPkg::*;
(
  input logic                 clk,
  input logic                 rst,
  input logic                 outValid,
  input logic                 outReady,
  input flitData_t            outFlit,
  input flitId_t              outFlitId,
  input portIdx_t             outPort,
  input logic [NUM_PORTS-1:0] pop
);

  int failCount = 0;  // polled by the testbench.

  // the output register comes out of reset empty.
  resetClearsValid: assert property (@(posedge clk) rst |=> !outValid)
  else
  begin
    failCount++;
    $error("outValid high after a reset cycle");
  end

  stalledFlitHolds: assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=>
      (outValid && $stable(outFlit) && $stable(outFlitId) && $stable(outPort)))
  else
  begin
    failCount++;
    $error("output flit changed while stalled");
  end

  // a pop hits a single buffer, and that port's flit is the next one registered.
  popFeedsOutput: assert property (@(posedge clk) disable iff (rst)
    (pop != '0) |=> (outValid && ($past(pop) == (NUM_PORTS'(1) << outPort))))
  else
  begin
    failCount++;
    $error("popped buffer does not match the port in the output register");
  end

endmodule

//--- verification/tb_routerOutputStage.sv
`timescale 1ns/1ps

module tb_routerOutputStage
  import flitPkg::*;
  import arbPkg::*;
();

  localparam int      TIMEOUT  = 200;
  localparam int      MAX_FLIT = 8;
  localparam flitId_t BODY_ID  = 3'd2;

  logic                      clk;
  logic                      rst;
  logic      [NUM_PORTS-1:0] inValid;
  logic      [NUM_PORTS-1:0] inReady;
  flitId_t   [NUM_PORTS-1:0] inFlitId;
  flitData_t [NUM_PORTS-1:0] inFlit;
  logic                      outValid;
  logic                      outReady;
  flitData_t                 outFlit;
  flitId_t                   outFlitId;
  portIdx_t                  outPort;

  // flits written per port, and the budget each port should hold.
  flitData_t stimData [NUM_PORTS][MAX_FLIT];
  flitId_t   stimId [NUM_PORTS][MAX_FLIT];
  int        stimCnt [NUM_PORTS];
  int        portBudget [NUM_PORTS];
  int        expPort [$];
  flitId_t   expId [$];
  flitData_t expData [$];
  logic [31:0] lfsrState;

  routerOutputStage u_routerOutputStage (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inReady   (inReady),
    .inFlitId  (inFlitId),
    .inFlit    (inFlit),
    .outValid  (outValid),
    .outReady  (outReady),
    .outFlit   (outFlit),
    .outFlitId (outFlitId),
    .outPort   (outPort)
  );

  bind routerOutputStage routerOutputStage_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .outValid  (outValid),
    .outReady  (outReady),
    .outFlit   (outFlit),
    .outFlitId (outFlitId),
    .outPort   (outPort),
    .pop       (pop)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abortRun();
    $display("TEST FAILED");
    $fatal(1, "run stopped on the first error");
  endtask

  always @(negedge clk)
  begin
    if (u_routerOutputStage.u_chk.failCount != 0)
    begin
      $display("an assertion on the output stage failed");
      abortRun();
    end
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1.
  endfunction

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  function automatic flitData_t headerFlit(input int p, input int b);
    return {8'(8'hA0 + p), 12'h000, sliceLen_t'(b)};
  endfunction

  function automatic flitData_t bodyFlit(input int p, input int k);
    return {8'(8'hB0 + p), 24'(k)};
  endfunction

  task automatic clearStim();
    for (int p = 0; p < NUM_PORTS; p++)
      stimCnt[p] = 0;
  endtask

  task automatic addFlit(input int p, input flitId_t id, input flitData_t d);
    stimData[p][stimCnt[p]] = d;
    stimId[p][stimCnt[p]]   = id;
    stimCnt[p]++;
    if (id == HEADER_ID)
      portBudget[p] = int'(d[11:0]);  // low payload bits carry the slice length.
  endtask

  task automatic stagePacket(input int p, input int b, input int bodies);
    addFlit(p, HEADER_ID, headerFlit(p, b));
    for (int k = 0; k < bodies; k++)
      addFlit(p, BODY_ID, bodyFlit(p, k));
  endtask

  task automatic sendFlit(input int p, input flitId_t id, input flitData_t d);
    logic done;
    done = 1'b0;
    addFlit(p, id, d);
    inFlit[p]   = d;
    inFlitId[p] = id;
    inValid[p]  = 1'b1;
    for (int t = 0; t < TIMEOUT && !done; t++)
    begin
      @(negedge clk);
      done = inReady[p];
      nextCycle();
    end
    inValid[p] = 1'b0;
    if (!done)
    begin
      $display("port %0d never accepted a flit", p);
      abortRun();
    end
  endtask

  // writes every staged flit, all ports in parallel.
  task automatic loadPorts();
    int   sent [NUM_PORTS];
    logic busy;
    for (int p = 0; p < NUM_PORTS; p++)
      sent[p] = 0;
    busy = 1'b1;
    for (int t = 0; t < TIMEOUT && busy; t++)
    begin
      busy = 1'b0;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        inValid[p] = (sent[p] < stimCnt[p]);
        if (inValid[p])
        begin
          inFlit[p]   = stimData[p][sent[p]];
          inFlitId[p] = stimId[p][sent[p]];
          busy        = 1'b1;
        end
      end
      @(negedge clk);
      for (int p = 0; p < NUM_PORTS; p++)
        if (inValid[p] && inReady[p])
          sent[p]++;
      nextCycle();
    end
    inValid = '0;
    if (busy)
    begin
      $display("input ports did not take all staged flits");
      abortRun();
    end
  endtask

  // order the rule predicts when the flits are all queued before the drain.
  task automatic buildExpected();
    int rem [NUM_PORTS];
    int pos [NUM_PORTS];
    int cur;
    int nxt;
    int sent;
    int left;
    expPort.delete();
    expId.delete();
    expData.delete();
    left = 0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      rem[p] = stimCnt[p];
      pos[p] = 0;
      left += stimCnt[p];
    end
    cur  = -1;
    sent = 0;
    while (left > 0)
    begin
      if (cur < 0)
      begin
        for (int k = NUM_PORTS - 1; k >= 0; k--)
          if (rem[k] > 0)
            cur = k;
        sent = 0;
      end
      expPort.push_back(cur);
      expId.push_back(stimId[cur][pos[cur]]);
      expData.push_back(stimData[cur][pos[cur]]);
      pos[cur]++;
      rem[cur]--;
      left--;
      sent++;
      if (rem[cur] == 0 || sent >= ((portBudget[cur] == 0) ? 1 : portBudget[cur]))
      begin
        nxt = -1;
        for (int k = NUM_PORTS - 1; k >= 1; k--)
          if (rem[(cur + k) % NUM_PORTS] > 0)
            nxt = (cur + k) % NUM_PORTS;
        cur  = nxt;  // -1 means idle.
        sent = 0;
      end
    end
  endtask

  task automatic expectFlit(input int p, input flitId_t id, input flitData_t d, input logic rnd);
    logic done;
    done = 1'b0;
    for (int t = 0; t < TIMEOUT && !done; t++)
    begin
      if (rnd)
      begin
        lfsrState = lfsrNext(lfsrState);
        outReady  = lfsrState[0];
      end
      else
        outReady = 1'b1;
      @(negedge clk);
      if (outValid && outReady)
      begin
        checkEq("outPort", outPort, p);
        checkEq("outFlitId", outFlitId, id);
        checkEq("outFlit", outFlit, d);
        done = 1'b1;
      end
      nextCycle();
    end
    if (!done)
    begin
      $display("no flit from port %0d reached the output", p);
      abortRun();
    end
  endtask

  task automatic drainExpected(input logic rnd);
    int        p;
    flitId_t   id;
    flitData_t d;
    while (expPort.size() > 0)
    begin
      p  = expPort.pop_front();
      id = expId.pop_front();
      d  = expData.pop_front();
      expectFlit(p, id, d, rnd);
    end
    outReady = 1'b1;
    repeat (8)
    begin
      @(negedge clk);
      checkEq("outValid", outValid, 1'b0);  // nothing beyond the expected flits.
      nextCycle();
    end
  endtask

  task automatic testResetAndStream();
    @(negedge clk);
    checkEq("outValid", outValid, 1'b0);
    checkEq("inReady", inReady, {NUM_PORTS{1'b1}});
    nextCycle();
    clearStim();
    outReady = 1'b0;
    sendFlit(PORT_E, HEADER_ID, headerFlit(PORT_E, 8));
    for (int k = 0; k < 3; k++)
      sendFlit(PORT_E, BODY_ID, bodyFlit(PORT_E, k));
    buildExpected();
    drainExpected(1'b0);
  endtask

  task automatic testStartFromIdle();
    clearStim();
    outReady = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++)
      stagePacket(p, 4, 3);
    loadPorts();
    buildExpected();
    drainExpected(1'b0);
  endtask

  task automatic testSliceExpiry(input logic rnd);
    clearStim();
    outReady = 1'b0;
    stagePacket(PORT_N, 2, 2);
    stagePacket(PORT_W, 2, 2);
    loadPorts();
    buildExpected();
    drainExpected(rnd);
  endtask

  task automatic testBufferFull();
    clearStim();
    outReady = 1'b0;
    sendFlit(PORT_S, HEADER_ID, headerFlit(PORT_S, 255));
    for (int k = 0; k < FIFO_DEPTH; k++)
      sendFlit(PORT_S, BODY_ID, bodyFlit(PORT_S, k));
    // one flit sits in the output register, the buffer holds the rest.
    inFlit[PORT_S]   = 32'hDEAD_0006;
    inFlitId[PORT_S] = BODY_ID;
    inValid[PORT_S]  = 1'b1;
    repeat (4)
    begin
      @(negedge clk);
      checkEq("inReady[S]", inReady[PORT_S], 1'b0);
      nextCycle();
    end
    inValid[PORT_S] = 1'b0;
    buildExpected();
    drainExpected(1'b0);
  endtask

  initial
  begin
    rst       = 1'b1;
    inValid   = '0;
    inFlitId  = '0;
    inFlit    = '0;
    outReady  = 1'b0;
    lfsrState = 32'he02e;
    clearStim();
    for (int p = 0; p < NUM_PORTS; p++)
      portBudget[p] = RESET_BUDGET;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    testResetAndStream();
    testStartFromIdle();
    testSliceExpiry(1'b0);
    testSliceExpiry(1'b1);  // same traffic under random stalls.
    testBufferFull();
    if (u_routerOutputStage.u_chk.failCount != 0)
    begin
      $display("an assertion on the output stage failed");
      abortRun();
    end
    else
    begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

//--- routerOutputStage.f
rtl/flitPkg.sv
rtl/arbPkg.sv
rtl/portBuffer.sv
rtl/sliceArbiter.sv
rtl/linkOutput.sv
rtl/routerOutputStage.sv
verification/routerOutputStage_chk.sv
verification/tb_routerOutputStage.sv

//--- Makefile
# Verilator build and run for the router output stage.

VERILATOR ?= verilator
TOP       ?= tb_routerOutputStage
FILELIST  ?= routerOutputStage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
